// ==== logic/iq_pkg.sv ====
package iq_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int XLEN  = 32;
    localparam int TAG_W = 6;

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [TAG_W-1:0] tag_t;

    // ------------------------------
    // alu opcodes
    // ------------------------------
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        // shift amount is the low 5 bits of src1
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        // signed compare, result is 1 or 0
        ALU_SLT = 3'd7
    } alu_op_t;

    // ------------------------------
    // structs
    // ------------------------------

    // one source, present when valid is set, otherwise waiting on tag
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } operand_t;

    // per-instruction state held in a queue slot
    typedef struct packed {
        alu_op_t  op;
        tag_t     dst;
        operand_t src0;
        operand_t src1;
    } uop_t;

    // one broadcast of a finished result
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } bus_t;

    // capture bus data into an awaited source on a tag match
    function automatic operand_t wakeup(operand_t src, bus_t bus);
        operand_t res;
        res = src;
        if (!src.valid && bus.valid && (bus.tag == src.tag)) begin
            res.valid = 1'b1;
            res.data  = bus.data;
        end
        return res;
    endfunction

endpackage

// ==== logic/iq_dispatch.sv ====
`timescale 1ns/1ps

module iq_dispatch import iq_pkg::*; #(
    parameter int IQ_SIZE = 4
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               disp_valid_i,
    input  uop_t               disp_uop_i,
    input  logic [IQ_SIZE-1:0] occupied_i,
    input  bus_t               cdb_i,
    output logic [IQ_SIZE-1:0] alloc_o,
    output uop_t               alloc_uop_o,
    output logic               entry_ready_o
);

    logic [IQ_SIZE-1:0] free_first;

    // ------------------------------
    // free slot search
    // ------------------------------

    // queue can take one more while any slot is empty
    assign entry_ready_o = ~&occupied_i;

    // one-hot of the lowest empty slot
    always_comb begin
        logic found;
        found      = 1'b0;
        free_first = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!occupied_i[i] && !found) begin
                free_first[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    assign alloc_o = disp_valid_i ? free_first : '0;

    // ------------------------------
    // same-cycle bus capture
    // ------------------------------

    // the entry only starts snooping next cycle, so a broadcast
    // landing on the dispatch cycle is caught here
    always_comb begin
        alloc_uop_o      = disp_uop_i;
        alloc_uop_o.src0 = wakeup(disp_uop_i.src0, cdb_i);
        alloc_uop_o.src1 = wakeup(disp_uop_i.src1, cdb_i);
    end

    // ------------------------------
    // checks
    // ------------------------------

    // upstream must respect the full indication
    a_no_disp_when_full: assert property (
        @(posedge clk) disable iff (rst_i)
        disp_valid_i |-> entry_ready_o
    ) else $error("dispatch while queue full, occupied=%h", occupied_i);

endmodule

// ==== logic/iq_entry.sv ====
`timescale 1ns/1ps

module iq_entry import iq_pkg::*; #(
    parameter int AGE_BITS = 3
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                flush_i,
    input  logic                alloc_i,
    input  uop_t                alloc_uop_i,
    input  logic                grant_i,
    input  bus_t                cdb_i,
    input  bus_t                self_i,
    output logic                occupied_o,
    output logic                ready_o,
    output logic [AGE_BITS-1:0] age_o,
    output uop_t                uop_o
);

    logic                occupied_q;
    logic [AGE_BITS-1:0] age_q;
    uop_t                uop_q;
    operand_t            src0_nxt;
    operand_t            src1_nxt;

    // ------------------------------
    // occupancy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            occupied_q <= 1'b0;
        end else if (alloc_i) begin
            occupied_q <= 1'b1;
        end else if (grant_i) begin
            occupied_q <= 1'b0;
        end
    end

    // ------------------------------
    // wakeup snoop
    // ------------------------------

    // external bus first, own result second, both are checked every cycle
    assign src0_nxt = wakeup(wakeup(uop_q.src0, cdb_i), self_i);
    assign src1_nxt = wakeup(wakeup(uop_q.src1, cdb_i), self_i);

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            uop_q <= alloc_uop_i;
        end else begin
            uop_q.src0 <= src0_nxt;
            uop_q.src1 <= src1_nxt;
        end
    end

    // ------------------------------
    // age
    // ------------------------------

    // saturating count of cycles spent waiting
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            age_q <= '0;
        end else if (alloc_i) begin
            age_q <= '0;
        end else if (occupied_q && (age_q != '1)) begin
            age_q <= age_q + 1'b1;
        end
    end

    assign occupied_o = occupied_q;
    assign ready_o    = occupied_q && uop_q.src0.valid && uop_q.src1.valid;
    assign age_o      = age_q;
    assign uop_o      = uop_q;

    // ------------------------------
    // checks
    // ------------------------------

    // allocator only targets empty slots, selector only ready ones
    a_alloc_grant_excl: assert property (
        @(posedge clk) disable iff (rst_i)
        !(alloc_i && grant_i)
    ) else $error("entry allocated and granted in the same cycle");

    a_grant_needs_ready: assert property (
        @(posedge clk) disable iff (rst_i)
        grant_i |-> ready_o
    ) else $error("entry granted while not ready");

endmodule

// ==== logic/iq_select.sv ====
`timescale 1ns/1ps

module iq_select import iq_pkg::*; #(
    parameter int IQ_SIZE  = 4,
    parameter int AGE_BITS = 3
) (
    input  logic [IQ_SIZE-1:0]               ready_i,
    input  logic [IQ_SIZE-1:0][AGE_BITS-1:0] age_i,
    input  uop_t [IQ_SIZE-1:0]               uop_i,
    input  logic                             accept_i,
    output logic [IQ_SIZE-1:0]               grant_o,
    output logic                             issue_o,
    output uop_t                             issue_uop_o
);

    localparam int IDX_W  = (IQ_SIZE > 1) ? $clog2(IQ_SIZE) : 1;
    localparam int LEAVES = 1 << $clog2(IQ_SIZE);
    localparam int NODES  = 2 * LEAVES - 1;

    logic                node_vld [NODES];
    logic [AGE_BITS-1:0] node_age [NODES];
    logic [IDX_W-1:0]    node_idx [NODES];
    logic [IDX_W-1:0]    best_idx;

    // ------------------------------
    // oldest-ready tree
    // ------------------------------

    // leaves at LEAVES-1.., children of n at 2n+1 (lower index) and 2n+2
    always_comb begin
        for (int n = 0; n < NODES; n++) begin
            node_vld[n] = 1'b0;
            node_age[n] = '0;
            node_idx[n] = '0;
        end
        for (int i = 0; i < IQ_SIZE; i++) begin
            node_vld[LEAVES-1+i] = ready_i[i];
            node_age[LEAVES-1+i] = age_i[i];
            node_idx[LEAVES-1+i] = IDX_W'(i);
        end
        for (int n = LEAVES - 2; n >= 0; n--) begin
            // right side wins only when strictly older
            if (node_vld[2*n+2] &&
                (!node_vld[2*n+1] || (node_age[2*n+2] > node_age[2*n+1]))) begin
                node_vld[n] = node_vld[2*n+2];
                node_age[n] = node_age[2*n+2];
                node_idx[n] = node_idx[2*n+2];
            end else begin
                node_vld[n] = node_vld[2*n+1];
                node_age[n] = node_age[2*n+1];
                node_idx[n] = node_idx[2*n+1];
            end
        end
    end

    assign best_idx = node_idx[0];

    // ------------------------------
    // grant and issue mux
    // ------------------------------
    assign issue_o = accept_i && node_vld[0];

    always_comb begin
        grant_o = '0;
        if (issue_o) begin
            grant_o[best_idx] = 1'b1;
        end
    end

    assign issue_uop_o = uop_i[best_idx];

    // ------------------------------
    // checks
    // ------------------------------

    // at most one grant, and never to a slot that is not ready
    always_comb begin
        if (!$isunknown(ready_i) && !$isunknown(accept_i)) begin
            assert ($onehot0(grant_o) && ((grant_o & ~ready_i) == '0))
                else $error("bad grant %h for ready %h", grant_o, ready_i);
        end
    end

endmodule

// ==== logic/iq_alu.sv ====
`timescale 1ns/1ps

module iq_alu import iq_pkg::*; (
    input  logic clk,
    input  logic rst_i,
    input  logic flush_i,
    input  logic issue_i,
    input  uop_t issue_uop_i,
    input  logic fifo_ready_i,
    output logic accept_o,
    output bus_t result_o
);

    word_t a;
    word_t b;
    word_t alu_res;
    bus_t  result_q;

    // ------------------------------
    // datapath
    // ------------------------------
    assign a = issue_uop_i.src0.data;
    assign b = issue_uop_i.src1.data;

    always_comb begin
        unique case (issue_uop_i.op)
            ALU_ADD: alu_res = a + b;
            ALU_SUB: alu_res = a - b;
            ALU_AND: alu_res = a & b;
            ALU_OR:  alu_res = a | b;
            ALU_XOR: alu_res = a ^ b;
            ALU_SLL: alu_res = a << b[4:0];
            ALU_SRL: alu_res = a >> b[4:0];
            ALU_SLT: alu_res = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            default: alu_res = '0;
        endcase
    end

    // ------------------------------
    // result register
    // ------------------------------

    // room when empty or draining this cycle
    assign accept_o = !result_q.valid || fifo_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            result_q.valid <= 1'b0;
        end else if (issue_i) begin
            result_q.valid <= 1'b1;
        end else if (fifo_ready_i) begin
            result_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            result_q.tag  <= issue_uop_i.dst;
            result_q.data <= alu_res;
        end
    end

    assign result_o = result_q;

    // ------------------------------
    // checks
    // ------------------------------

    // a held result must not change until the fifo takes it
    a_hold_under_bp: assert property (
        @(posedge clk) disable iff (rst_i)
        (result_q.valid && !fifo_ready_i && !flush_i) |=> $stable(result_q)
    ) else $error("result changed under back-pressure");

endmodule

// ==== logic/alu_issue_queue.sv ====
`timescale 1ns/1ps

module alu_issue_queue import iq_pkg::*; #(
    parameter int IQ_SIZE  = 4,
    parameter int AGE_BITS = 3
) (
    input  logic clk,
    input  logic rst_i,
    input  logic flush_i,
    input  logic disp_valid_i,
    input  uop_t disp_uop_i,
    input  bus_t cdb_i,
    input  logic fifo_ready_i,
    output logic entry_ready_o,
    output bus_t result_o
);

    logic [IQ_SIZE-1:0]               alloc;
    uop_t                             alloc_uop;
    logic [IQ_SIZE-1:0]               occupied;
    logic [IQ_SIZE-1:0]               ready;
    logic [IQ_SIZE-1:0][AGE_BITS-1:0] age;
    uop_t [IQ_SIZE-1:0]               entry_uop;
    logic [IQ_SIZE-1:0]               grant;
    logic                             issue;
    uop_t                             issue_uop;
    logic                             accept;

    // ------------------------------
    // dispatch
    // ------------------------------
    iq_dispatch #(
        .IQ_SIZE(IQ_SIZE)
    ) u_dispatch (
        .clk           (clk),
        .rst_i         (rst_i),
        .disp_valid_i  (disp_valid_i),
        .disp_uop_i    (disp_uop_i),
        .occupied_i    (occupied),
        .cdb_i         (cdb_i),
        .alloc_o       (alloc),
        .alloc_uop_o   (alloc_uop),
        .entry_ready_o (entry_ready_o)
    );

    // ------------------------------
    // queue slots
    // ------------------------------

    // own result goes back to every slot as the second wakeup source
    for (genvar i = 0; i < IQ_SIZE; i++) begin : gen_entry
        iq_entry #(
            .AGE_BITS(AGE_BITS)
        ) u_entry (
            .clk         (clk),
            .rst_i       (rst_i),
            .flush_i     (flush_i),
            .alloc_i     (alloc[i]),
            .alloc_uop_i (alloc_uop),
            .grant_i     (grant[i]),
            .cdb_i       (cdb_i),
            .self_i      (result_o),
            .occupied_o  (occupied[i]),
            .ready_o     (ready[i]),
            .age_o       (age[i]),
            .uop_o       (entry_uop[i])
        );
    end

    // ------------------------------
    // select and execute
    // ------------------------------
    iq_select #(
        .IQ_SIZE (IQ_SIZE),
        .AGE_BITS(AGE_BITS)
    ) u_select (
        .ready_i     (ready),
        .age_i       (age),
        .uop_i       (entry_uop),
        .accept_i    (accept),
        .grant_o     (grant),
        .issue_o     (issue),
        .issue_uop_o (issue_uop)
    );

    iq_alu u_alu (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .issue_i      (issue),
        .issue_uop_i  (issue_uop),
        .fifo_ready_i (fifo_ready_i),
        .accept_o     (accept),
        .result_o     (result_o)
    );

endmodule

// ==== verif/tb_alu_issue_queue.sv ====
`timescale 1ns/1ps

module tb_alu_issue_queue import iq_pkg::*; ();

    localparam int IQ_SIZE  = 4;
    localparam int AGE_BITS = 3;
    localparam int N_IND    = 40;
    localparam int N_GRP    = 6;
    localparam int N_BP     = 30;
    // idle test counts as one, each dependent group holds three
    localparam int N_TOTAL  = 1 + N_IND + 3 * N_GRP + N_BP + IQ_SIZE + IQ_SIZE + 4;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 40;
    localparam bus_t BUS_IDLE = '0;

    logic clk;
    logic rst_i;
    logic flush_i;
    logic disp_valid_i;
    uop_t disp_uop_i;
    bus_t cdb_i;
    logic fifo_ready_i;
    logic entry_ready_o;
    bus_t result_o;

    // reference model state
    word_t                 tag_val [1<<TAG_W];
    logic [(1<<TAG_W)-1:0] outstanding;
    int                    pending;
    int                    occ_base;
    int                    occ_now;
    logic                  prev_accept;
    logic                  issued_last;
    logic                  took;
    logic                  retire;
    logic                  seen_disp;
    tag_t                  next_tag;
    int                    fifo_mode  = 0;
    int                    assert_err = 0;
    int                    drain_err  = 0;
    int                    test_num   = 0;

    alu_issue_queue #(
        .IQ_SIZE (IQ_SIZE),
        .AGE_BITS(AGE_BITS)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 0 always ready, 1 random stalls, 2 stalled
    initial begin
        fifo_ready_i = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (fifo_mode == 1) begin
                fifo_ready_i = 1'($urandom_range(0, 1));
            end else begin
                fifo_ready_i = (fifo_mode == 0);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    // ------------------------------
    // reference model
    // ------------------------------
    assign took        = disp_valid_i && entry_ready_o;
    assign retire      = result_o.valid && fifo_ready_i && outstanding[result_o.tag];
    // a result that appears while the stage could accept means an issue at that edge
    assign issued_last = result_o.valid && prev_accept;
    assign occ_now     = occ_base - (issued_last ? 1 : 0);

    always @(posedge clk) begin
        if (rst_i || flush_i) begin
            outstanding <= '0;
            pending     <= 0;
            occ_base    <= 0;
            prev_accept <= 1'b0;
            seen_disp   <= 1'b0;
        end else begin
            if (took) begin
                outstanding[disp_uop_i.dst] <= 1'b1;
                seen_disp                   <= 1'b1;
            end
            if (retire) begin
                outstanding[result_o.tag] <= 1'b0;
            end
            pending     <= pending + (took ? 1 : 0) - (retire ? 1 : 0);
            occ_base    <= occ_base + (took ? 1 : 0) - (issued_last ? 1 : 0);
            prev_accept <= !result_o.valid || fifo_ready_i;
        end
    end

    function automatic word_t expected_result(alu_op_t op, word_t x, word_t y);
        word_t r;
        case (op)
            ALU_ADD: r = x + y;
            ALU_SUB: r = x + ~y + word_t'(1);
            ALU_AND: r = x & y;
            ALU_OR:  r = x | y;
            ALU_XOR: r = x ^ y;
            ALU_SLL: r = x << y[4:0];
            ALU_SRL: r = x >> y[4:0];
            default: begin
                // slt: differing signs decide, else plain magnitude order
                if (x[XLEN-1] != y[XLEN-1]) begin
                    r = {{(XLEN-1){1'b0}}, x[XLEN-1]};
                end else begin
                    r = {{(XLEN-1){1'b0}}, x < y};
                end
            end
        endcase
        return r;
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    a_idle: assert property (@(posedge clk) disable iff (rst_i)
        !seen_disp |-> (!result_o.valid && entry_ready_o))
        else begin
            $display("Error: idle queue has result_o.valid = %h, entry_ready_o = %h",
                     $sampled(result_o.valid), $sampled(entry_ready_o));
            assert_err++;
        end

    a_tag_known: assert property (@(posedge clk) disable iff (rst_i)
        (result_o.valid && fifo_ready_i) |-> outstanding[result_o.tag])
        else begin
            $display("result with tag %h arrived but no such instruction was waiting",
                     $sampled(result_o.tag));
            assert_err++;
        end

    a_data: assert property (@(posedge clk) disable iff (rst_i)
        retire |-> (result_o.data == tag_val[result_o.tag]))
        else begin
            $display("Error: result_o.data = %h, expected %h for tag %h",
                     $sampled(result_o.data), tag_val[$sampled(result_o.tag)],
                     $sampled(result_o.tag));
            assert_err++;
        end

    a_hold: assert property (@(posedge clk) disable iff (rst_i)
        (result_o.valid && !fifo_ready_i && !flush_i) |=> $stable(result_o))
        else begin
            $display("Error: result_o = %h changed while held", $sampled(result_o));
            assert_err++;
        end

    a_full_flag: assert property (@(posedge clk) disable iff (rst_i)
        entry_ready_o == (occ_now < IQ_SIZE))
        else begin
            $display("Error: entry_ready_o = %h with %h occupants",
                     $sampled(entry_ready_o), $sampled(occ_now));
            assert_err++;
        end

    a_flush: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> (!result_o.valid && entry_ready_o))
        else begin
            $display("Error: after flush result_o.valid = %h, entry_ready_o = %h",
                     $sampled(result_o.valid), $sampled(entry_ready_o));
            assert_err++;
        end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic tag_t take_tag();
        take_tag = next_tag;
        next_tag = next_tag + 1'b1;
    endfunction

    function automatic alu_op_t rand_op();
        return alu_op_t'(3'($urandom));
    endfunction

    function automatic operand_t src_now();
        operand_t o;
        o.valid = 1'b1;
        o.tag   = tag_t'($urandom);
        o.data  = word_t'($urandom);
        return o;
    endfunction

    // data field is junk that must never be used
    function automatic operand_t src_wait(tag_t t);
        operand_t o;
        o.valid = 1'b0;
        o.tag   = t;
        o.data  = word_t'($urandom);
        return o;
    endfunction

    function automatic bus_t bus_of(tag_t t);
        bus_t b;
        b.valid = 1'b1;
        b.tag   = t;
        b.data  = tag_val[t];
        return b;
    endfunction

    task automatic broadcast(input tag_t t);
        cdb_i = bus_of(t);
        idle_cycles(1);
        cdb_i = BUS_IDLE;
    endtask

    task automatic send_uop(input alu_op_t opc, input tag_t dst, input operand_t s0,
                            input operand_t s1, input bus_t same_cycle);
        word_t v0;
        word_t v1;
        v0 = s0.valid ? s0.data : tag_val[s0.tag];
        v1 = s1.valid ? s1.data : tag_val[s1.tag];
        tag_val[dst] = expected_result(opc, v0, v1);
        while (!entry_ready_o) begin
            idle_cycles(1);
        end
        disp_valid_i    = 1'b1;
        disp_uop_i.op   = opc;
        disp_uop_i.dst  = dst;
        disp_uop_i.src0 = s0;
        disp_uop_i.src1 = s1;
        cdb_i           = same_cycle;
        idle_cycles(1);
        disp_valid_i = 1'b0;
        cdb_i        = BUS_IDLE;
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (pending != 0 && waited < 200) begin
            idle_cycles(1);
            waited++;
        end
        if (pending != 0) begin
            $display("test %s: %0d dispatched instructions never produced a result",
                     name, pending);
            drain_err++;
        end
        test_num++;
        $display("test %0d (%s) finished, errors so far %0d",
                 test_num, name, assert_err + drain_err);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        tag_t x;
        tag_t y;
        tag_t a;
        tag_t b;
        void'($urandom(50276));
        rst_i        = 1'b1;
        flush_i      = 1'b0;
        disp_valid_i = 1'b0;
        disp_uop_i   = '0;
        cdb_i        = BUS_IDLE;
        next_tag     = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;

        idle_cycles(6);
        finish_test("idle after reset");

        // op index walks all eight opcodes
        for (int k = 0; k < N_IND; k++) begin
            send_uop(alu_op_t'(3'(k)), take_tag(), src_now(), src_now(), BUS_IDLE);
        end
        finish_test("independent ops");

        // chain a -> b -> c, with x sent late and y on the dispatch cycle of a
        for (int g = 0; g < N_GRP; g++) begin
            x = take_tag();
            y = take_tag();
            a = take_tag();
            b = take_tag();
            tag_val[x] = word_t'($urandom);
            tag_val[y] = word_t'($urandom);
            send_uop(rand_op(), a, src_wait(x), src_wait(y), bus_of(y));
            send_uop(rand_op(), b, src_wait(a), src_now(), BUS_IDLE);
            send_uop(rand_op(), take_tag(), src_wait(b), src_wait(x), BUS_IDLE);
            idle_cycles(int'($urandom_range(0, 3)));
            broadcast(x);
        end
        finish_test("dependent ops");

        fifo_mode = 1;
        for (int k = 0; k < N_BP; k++) begin
            send_uop(rand_op(), take_tag(), src_now(), src_now(), BUS_IDLE);
        end
        finish_test("random back-pressure");

        fifo_mode = 2;
        x = take_tag();
        tag_val[x] = word_t'($urandom);
        for (int k = 0; k < IQ_SIZE; k++) begin
            send_uop(rand_op(), take_tag(), src_wait(x), src_now(), BUS_IDLE);
        end
        idle_cycles(4);
        broadcast(x);
        idle_cycles(4);
        fifo_mode = 0;
        finish_test("queue full");

        // one result held, the rest waiting on a tag that comes after the flush
        fifo_mode = 2;
        idle_cycles(1);
        send_uop(rand_op(), take_tag(), src_now(), src_now(), BUS_IDLE);
        x = take_tag();
        tag_val[x] = word_t'($urandom);
        for (int k = 0; k < IQ_SIZE - 1; k++) begin
            send_uop(rand_op(), take_tag(), src_wait(x), src_now(), BUS_IDLE);
        end
        idle_cycles(3);
        flush_i = 1'b1;
        idle_cycles(1);
        flush_i = 1'b0;
        broadcast(x);
        fifo_mode = 0;
        for (int k = 0; k < 4; k++) begin
            send_uop(rand_op(), take_tag(), src_now(), src_now(), BUS_IDLE);
        end
        finish_test("flush");

        idle_cycles(5);
        $display("summary: %0d tests, %0d assertion failures, %0d missing-result failures",
                 test_num, assert_err, drain_err);
        if (assert_err + drain_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/iq_pkg.sv
logic/iq_dispatch.sv
logic/iq_entry.sv
logic/iq_select.sv
logic/iq_alu.sv
logic/alu_issue_queue.sv
verif/tb_alu_issue_queue.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only when the simulation prints the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 --top-module tb_alu_issue_queue -f src.f \
    && ./obj_dir/Vtb_alu_issue_queue | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
